/* sim.f */
+incdir+sim
rtl/rayPkg.sv
rtl/rayRangeSequencer.sv
rtl/rayBoxBatchTest.sv
rtl/rayHitTracker.sv
rtl/rayShadeOutput.sv
rtl/rayCore.sv
sim/rayCoreTb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = rayCoreTb
FILELIST = sim.f

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir

/* sim/rayCoreCases.svh */
`ifndef RAY_CORE_CASES_SVH
`define RAY_CORE_CASES_SVH

// ----------------------------------------------------------------------------
// scene: four columns of eight boxes along x, facing a ray that travels +z
// ----------------------------------------------------------------------------

localparam int SCENE_SIZE = 32;
localparam rayPkg::colorT CLEAR_COLOR = 24'h203040;

// whole number to Q16.16
function automatic rayPkg::fixedT toFixed(input int value);
    return rayPkg::fixedT'(value <<< rayPkg::FRAC_BITS);
endfunction

// near z face, with a tie between boxes 2 and 5 of each column
function automatic int boxNearZ(input int index);
    int nearZ;
    case (index % 8)
        0: nearZ = 30;
        1: nearZ = 22;
        2: nearZ = 14;
        3: nearZ = 26;
        4: nearZ = 18;
        5: nearZ = 14;
        6: nearZ = 34;
        default: nearZ = 10;
    endcase
    return nearZ + index / 8;
endfunction

function automatic rayPkg::fixedVec3T boxLoOf(input int index);
    rayPkg::fixedVec3T lo;
    lo[0] = toFixed((index / 8) * 4 - 1);
    lo[1] = toFixed(-1);
    lo[2] = toFixed(boxNearZ(index));
    return lo;
endfunction

function automatic rayPkg::fixedVec3T boxHiOf(input int index);
    rayPkg::fixedVec3T hi;
    hi[0] = toFixed((index / 8) * 4 + 1);
    hi[1] = toFixed(1);
    hi[2] = toFixed(boxNearZ(index) + 2);
    return hi;
endfunction

function automatic rayPkg::colorT boxColorOf(input int index);
    rayPkg::colorT color;
    color[0] = 8'(index * 8);
    color[1] = 8'(255 - index * 8);
    color[2] = 8'(8'h40 + index);
    return color;
endfunction

// ----------------------------------------------------------------------------
// cases: ray fields, then expected outHit, outPrimIndex and outColor
// ----------------------------------------------------------------------------

typedef struct packed {
    rayPkg::rayKindE   kind;
    int                originX;
    int                maxDist;
    rayPkg::colorT     color;
    rayPkg::primIndexT first;
    rayPkg::primCountT count;
    logic              expHit;
    rayPkg::primIndexT expIndex;
    rayPkg::colorT     expColor;
} caseT;

localparam int NUM_CASES = 15;

caseT caseTable [NUM_CASES] = '{
    '{rayPkg::RAY_PRIMARY, 0, 100, 24'h808080, 16'd0, 8'd8, 1'b1, 16'd7, 24'h47C738},
    '{rayPkg::RAY_PRIMARY, 0, 100, 24'h808080, 16'd0, 8'd7, 1'b1, 16'd2, 24'h42EF10},
    '{rayPkg::RAY_PRIMARY, 0, 100, 24'h808080, 16'd2, 8'd4, 1'b1, 16'd2, 24'h42EF10},
    '{rayPkg::RAY_PRIMARY, 0, 100, 24'h808080, 16'd5, 8'd2, 1'b1, 16'd5, 24'h45D728},
    '{rayPkg::RAY_PRIMARY, 2, 100, 24'h808080, 16'd0, 8'd16, 1'b0, 16'd0, 24'h203040},
    '{rayPkg::RAY_PRIMARY, 0, 100, 24'h808080, 16'd0, 8'd0, 1'b0, 16'd0, 24'h203040},
    '{rayPkg::RAY_PRIMARY, 0, 10, 24'h808080, 16'd0, 8'd8, 1'b0, 16'd0, 24'h203040},
    '{rayPkg::RAY_PRIMARY, 0, 15, 24'h808080, 16'd0, 8'd8, 1'b1, 16'd7, 24'h47C738},
    '{rayPkg::RAY_SHADOW, 0, 100, 24'hFF7F81, 16'd0, 8'd8, 1'b1, 16'd2, 24'h7F3F40},
    '{rayPkg::RAY_SHADOW, 0, 100, 24'hFF7F81, 16'd8, 8'd8, 1'b0, 16'd0, 24'hFF7F81},
    '{rayPkg::RAY_SHADOW, 0, 9, 24'h123456, 16'd0, 8'd8, 1'b0, 16'd0, 24'h123456},
    '{rayPkg::RAY_PRIMARY, 8, 100, 24'h808080, 16'd16, 8'd8, 1'b1, 16'd23, 24'h5747B8},
    '{rayPkg::RAY_PRIMARY, 8, 100, 24'h808080, 16'd13, 8'd6, 1'b1, 16'd18, 24'h526F90},
    '{rayPkg::RAY_SHADOW, 0, 100, 24'h0A0B0C, 16'd4, 8'd12, 1'b1, 16'd7, 24'h050506},
    '{rayPkg::RAY_SHADOW, 12, 100, 24'h204060, 16'd30, 8'd2, 1'b1, 16'd31, 24'h102030}
};

`endif

/* sim/rayCoreTb.sv */
`timescale 1ns/1ns

module rayCoreTb;

    `include "rayCoreCases.svh"

    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_CASE = 200;
    localparam int INV_XY = 1024;

    logic               clk;
    logic               resetn;
    logic               addInput;
    rayPkg::rayKindE    inKind;
    rayPkg::pixelCoordT inX;
    rayPkg::pixelCoordT inY;
    rayPkg::fixedVec3T  inOrigin;
    rayPkg::fixedVec3T  inInvDir;
    rayPkg::fixedT      inMaxT;
    rayPkg::colorT      inColor;
    rayPkg::primIndexT  inPrimStart;
    rayPkg::primCountT  inPrimCount;
    rayPkg::colorT      clearColor;
    logic               outputStall;
    rayPkg::fixedVec3T  boxLo [rayPkg::BATCH_SIZE];
    rayPkg::fixedVec3T  boxHi [rayPkg::BATCH_SIZE];
    rayPkg::colorT      boxColor [rayPkg::BATCH_SIZE];
    rayPkg::primIndexT  batchStart;
    logic               inputFull;
    logic               valid;
    rayPkg::pixelCoordT outX;
    rayPkg::pixelCoordT outY;
    logic               outHit;
    rayPkg::primIndexT  outPrimIndex;
    rayPkg::colorT      outColor;

    int         errorCount;
    int         pending [$];
    bit         stallPattern [256];
    int         gapCycles [NUM_CASES];
    logic [7:0] stallCycle;
    logic       haveHeld;
    logic [31:0] heldX;
    logic [31:0] heldY;
    logic [31:0] heldHit;
    logic [31:0] heldIndex;
    logic [31:0] heldColor;

    rayCore DUT (
        .clk(clk), .resetn(resetn), .addInput(addInput),
        .inKind(inKind), .inX(inX), .inY(inY),
        .inOrigin(inOrigin), .inInvDir(inInvDir), .inMaxT(inMaxT),
        .inColor(inColor), .inPrimStart(inPrimStart), .inPrimCount(inPrimCount),
        .clearColor(clearColor), .outputStall(outputStall),
        .boxLo(boxLo), .boxHi(boxHi), .boxColor(boxColor),
        .batchStart(batchStart), .inputFull(inputFull), .valid(valid),
        .outX(outX), .outY(outY), .outHit(outHit),
        .outPrimIndex(outPrimIndex), .outColor(outColor)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // primitive memory, answers in the same cycle
    always_comb begin
        int addr;
        for (int lane = 0; lane < rayPkg::BATCH_SIZE; lane++) begin
            addr = int'(batchStart) + lane;
            if (addr < SCENE_SIZE) begin
                boxLo[lane]    = boxLoOf(addr);
                boxHi[lane]    = boxHiOf(addr);
                boxColor[lane] = boxColorOf(addr);
            end else begin
                boxLo[lane]    = {3{toFixed(addr)}};
                boxHi[lane]    = {3{toFixed(addr)}};
                boxColor[lane] = rayPkg::colorT'(addr);
            end
        end
    end

    always @(posedge clk) begin
        outputStall <= stallPattern[stallCycle];
        stallCycle  <= stallCycle + 8'd1;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    function automatic rayPkg::fixedVec3T rayOrigin(input int originX);
        rayPkg::fixedVec3T origin;
        origin[0] = toFixed(originX);
        origin[1] = '0;
        origin[2] = '0;
        return origin;
    endfunction

    // ray heads along +z, nearly parallel to x and y
    function automatic rayPkg::fixedVec3T rayInvDir();
        rayPkg::fixedVec3T invDir;
        invDir[0] = toFixed(INV_XY);
        invDir[1] = toFixed(INV_XY);
        invDir[2] = toFixed(1);
        return invDir;
    endfunction

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic logic boxHit(input int index, input int originX,
                                    input rayPkg::fixedT maxT,
                                    output rayPkg::fixedT tEntry);
        rayPkg::fixedVec3T lo;
        rayPkg::fixedVec3T hi;
        rayPkg::fixedVec3T origin;
        rayPkg::fixedVec3T invDir;
        rayPkg::fixedT     tExit;
        rayPkg::fixedT     tA;
        rayPkg::fixedT     tB;
        lo     = boxLoOf(index);
        hi     = boxHiOf(index);
        origin = rayOrigin(originX);
        invDir = rayInvDir();
        tEntry = '0;
        tExit  = rayPkg::FIXED_MAX;
        for (int axis = 0; axis < 3; axis++) begin
            tA = rayPkg::fixedT'((longint'(lo[axis] - origin[axis]) *
                                  longint'(invDir[axis])) >>> rayPkg::FRAC_BITS);
            tB = rayPkg::fixedT'((longint'(hi[axis] - origin[axis]) *
                                  longint'(invDir[axis])) >>> rayPkg::FRAC_BITS);
            if ((tA < tB ? tA : tB) > tEntry) begin
                tEntry = tA < tB ? tA : tB;
            end
            if ((tA < tB ? tB : tA) < tExit) begin
                tExit = tA < tB ? tB : tA;
            end
        end
        return (tEntry <= tExit) && (tEntry < maxT);
    endfunction

    function automatic void predict(input caseT c, output logic hit,
                                    output rayPkg::primIndexT index,
                                    output rayPkg::colorT color);
        rayPkg::fixedT bestT;
        rayPkg::fixedT tEntry;
        rayPkg::colorT primColor;
        logic          laneHit;
        int            trueEnd;
        int            alignedEnd;
        hit        = 1'b0;
        index      = '0;
        bestT      = rayPkg::FIXED_MAX;
        trueEnd    = int'(c.first) + int'(c.count);
        alignedEnd = int'(c.first) + (int'(c.count) + rayPkg::BATCH_SIZE - 1) /
                     rayPkg::BATCH_SIZE * rayPkg::BATCH_SIZE;
        // shadow rays give up after the first batch that hits
        for (int batch = int'(c.first); batch < alignedEnd &&
             !(c.kind == rayPkg::RAY_SHADOW && hit); batch += rayPkg::BATCH_SIZE) begin
            for (int p = batch; p < batch + rayPkg::BATCH_SIZE && p < trueEnd; p++) begin
                laneHit = boxHit(p, c.originX, toFixed(c.maxDist), tEntry);
                if (laneHit && tEntry < bestT) begin
                    bestT = tEntry;
                    index = rayPkg::primIndexT'(p);
                    hit   = 1'b1;
                end
            end
        end
        primColor = boxColorOf(int'(index));
        for (int ch = 0; ch < 3; ch++) begin
            if (c.kind == rayPkg::RAY_SHADOW) begin
                color[ch] = hit ? c.color[ch] >> 1 : c.color[ch];
            end else begin
                color[ch] = hit ? primColor[ch] : CLEAR_COLOR[ch];
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin
        logic              refHit;
        rayPkg::primIndexT refIndex;
        rayPkg::colorT     refColor;
        void'($urandom(32'hd6e69f25));
        for (int i = 0; i < 256; i++) begin
            stallPattern[i] = ($urandom % 3) == 0;
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            gapCycles[i] = $urandom % 4;
        end
        resetn      = 1'b0;
        addInput    = 1'b0;
        inKind      = rayPkg::RAY_PRIMARY;
        inX         = '0;
        inY         = '0;
        inOrigin    = '0;
        inInvDir    = '0;
        inMaxT      = '0;
        inColor     = '0;
        inPrimStart = '0;
        inPrimCount = '0;
        clearColor  = CLEAR_COLOR;
        outputStall = 1'b0;
        stallCycle  = '0;
        haveHeld    = 1'b0;
        errorCount  = 0;
        // the table must agree with the hit rule
        for (int i = 0; i < NUM_CASES; i++) begin
            predict(caseTable[i], refHit, refIndex, refColor);
            checkValue($sformatf("table outHit, case %0d", i),
                       32'(refHit), 32'(caseTable[i].expHit));
            checkValue($sformatf("table outPrimIndex, case %0d", i),
                       32'(refIndex), 32'(caseTable[i].expIndex));
            checkValue($sformatf("table outColor, case %0d", i),
                       32'(refColor), 32'(caseTable[i].expColor));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            repeat (gapCycles[i]) @(posedge clk);
            @(negedge clk);
            while (inputFull) begin
                @(negedge clk);
            end
            @(posedge clk);
            addInput    <= 1'b1;
            inKind      <= caseTable[i].kind;
            inX         <= rayPkg::pixelCoordT'(i);
            inY         <= rayPkg::pixelCoordT'(2 * i);
            inOrigin    <= rayOrigin(caseTable[i].originX);
            inInvDir    <= rayInvDir();
            inMaxT      <= toFixed(caseTable[i].maxDist);
            inColor     <= caseTable[i].color;
            inPrimStart <= caseTable[i].first;
            inPrimCount <= caseTable[i].count;
            pending.push_back(i);
            @(posedge clk);
            addInput <= 1'b0;
            // buffer reads full for at least the cycle after acceptance
            @(negedge clk);
            checkValue("inputFull", 32'(inputFull), 32'd1);
        end
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("%0d errors", errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // results come back one per ray, in order, and hold between valids
    always @(negedge clk) begin
        int idx;
        if (resetn && valid) begin
            if (pending.size() == 0) begin
                errorCount++;
                $display("valid was raised with no ray outstanding");
            end else begin
                idx = pending.pop_front();
                checkValue("outX", 32'(outX), 32'(idx));
                checkValue("outY", 32'(outY), 32'(2 * idx));
                checkValue("outHit", 32'(outHit), 32'(caseTable[idx].expHit));
                checkValue("outPrimIndex", 32'(outPrimIndex), 32'(caseTable[idx].expIndex));
                checkValue("outColor", 32'(outColor), 32'(caseTable[idx].expColor));
            end
            heldX     = 32'(outX);
            heldY     = 32'(outY);
            heldHit   = 32'(outHit);
            heldIndex = 32'(outPrimIndex);
            heldColor = 32'(outColor);
            haveHeld  = 1'b1;
        end else if (haveHeld) begin
            checkValue("outX held", 32'(outX), heldX);
            checkValue("outY held", 32'(outY), heldY);
            checkValue("outHit held", 32'(outHit), heldHit);
            checkValue("outPrimIndex held", 32'(outPrimIndex), heldIndex);
            checkValue("outColor held", 32'(outColor), heldColor);
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_CASES * CYCLES_PER_CASE) @(posedge clk);
        $display("timeout: valid never arrived for %0d outstanding rays", pending.size());
        $display("%0d errors", errorCount + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* rtl/rayCore.sv */
`timescale 1ns/1ns

module rayCore (
    input  logic                clk,
    input  logic                resetn,
    input  logic                addInput,
    input  rayPkg::rayKindE     inKind,
    input  rayPkg::pixelCoordT  inX,
    input  rayPkg::pixelCoordT  inY,
    input  rayPkg::fixedVec3T   inOrigin,
    input  rayPkg::fixedVec3T   inInvDir,
    input  rayPkg::fixedT       inMaxT,
    input  rayPkg::colorT       inColor,
    input  rayPkg::primIndexT   inPrimStart,
    input  rayPkg::primCountT   inPrimCount,
    input  rayPkg::colorT       clearColor,
    input  logic                outputStall,
    input  rayPkg::fixedVec3T   boxLo [rayPkg::BATCH_SIZE],
    input  rayPkg::fixedVec3T   boxHi [rayPkg::BATCH_SIZE],
    input  rayPkg::colorT       boxColor [rayPkg::BATCH_SIZE],
    output rayPkg::primIndexT   batchStart,
    output logic                inputFull,
    output logic                valid,
    output rayPkg::pixelCoordT  outX,
    output rayPkg::pixelCoordT  outY,
    output logic                outHit,
    output rayPkg::primIndexT   outPrimIndex,
    output rayPkg::colorT       outColor
);

    rayPkg::rayKindE    curKind;
    rayPkg::pixelCoordT curX;
    rayPkg::pixelCoordT curY;
    rayPkg::fixedVec3T  curOrigin;
    rayPkg::fixedVec3T  curInvDir;
    rayPkg::fixedT      curMaxT;
    rayPkg::colorT      curColor;
    rayPkg::laneMaskT   laneMask;
    logic               batchActive;
    logic               rayStart;
    logic               rayDone;
    logic               batchHit;
    rayPkg::fixedT      batchNearT;
    rayPkg::laneIndexT  batchLane;
    logic               anyHit;
    rayPkg::primIndexT  bestIndex;
    rayPkg::colorT      hitColor;

    // decode
    rayRangeSequencer sequencer (
        .clk(clk), .resetn(resetn), .addInput(addInput),
        .inKind(inKind), .inX(inX), .inY(inY),
        .inOrigin(inOrigin), .inInvDir(inInvDir), .inMaxT(inMaxT),
        .inColor(inColor), .inPrimStart(inPrimStart), .inPrimCount(inPrimCount),
        .anyHit(anyHit), .outputStall(outputStall), .inputFull(inputFull),
        .curKind(curKind), .curX(curX), .curY(curY),
        .curOrigin(curOrigin), .curInvDir(curInvDir), .curMaxT(curMaxT),
        .curColor(curColor), .batchStart(batchStart), .laneMask(laneMask),
        .batchActive(batchActive), .rayStart(rayStart), .rayDone(rayDone)
    );

    // execute
    rayBoxBatchTest boxTest (
        .origin(curOrigin), .invDir(curInvDir), .maxT(curMaxT),
        .boxLo(boxLo), .boxHi(boxHi), .laneMask(laneMask),
        .batchHit(batchHit), .batchNearT(batchNearT), .batchLane(batchLane)
    );

    // bestT and bestLane only matter inside the tracker
    rayHitTracker hitTracker (
        .clk(clk), .resetn(resetn), .rayStart(rayStart),
        .batchActive(batchActive), .batchHit(batchHit),
        .batchNearT(batchNearT), .batchLane(batchLane),
        .batchStart(batchStart), .boxColor(boxColor),
        .anyHit(anyHit), .bestT(), .bestIndex(bestIndex),
        .bestLane(), .hitColor(hitColor)
    );

    // result
    rayShadeOutput shadeOutput (
        .clk(clk), .resetn(resetn), .rayDone(rayDone),
        .curKind(curKind), .curX(curX), .curY(curY),
        .curColor(curColor), .clearColor(clearColor),
        .anyHit(anyHit), .bestIndex(bestIndex), .hitColor(hitColor),
        .valid(valid), .outX(outX), .outY(outY), .outHit(outHit),
        .outPrimIndex(outPrimIndex), .outColor(outColor)
    );

endmodule

/* rtl/rayShadeOutput.sv */
`timescale 1ns/1ns

module rayShadeOutput (
    input  logic                clk,
    input  logic                resetn,
    input  logic                rayDone,
    input  rayPkg::rayKindE     curKind,
    input  rayPkg::pixelCoordT  curX,
    input  rayPkg::pixelCoordT  curY,
    input  rayPkg::colorT       curColor,
    input  rayPkg::colorT       clearColor,
    input  logic                anyHit,
    input  rayPkg::primIndexT   bestIndex,
    input  rayPkg::colorT       hitColor,
    output logic                valid,
    output rayPkg::pixelCoordT  outX,
    output rayPkg::pixelCoordT  outY,
    output logic                outHit,
    output rayPkg::primIndexT   outPrimIndex,
    output rayPkg::colorT       outColor
);

    rayPkg::colorT shadeColor;

    // ------------------------------------------------------------------------
    // colour rule
    // ------------------------------------------------------------------------

    always_comb begin
        if (curKind == rayPkg::RAY_SHADOW) begin
            // occluded pixels get every channel halved
            for (int ch = 0; ch < 3; ch++) begin
                if (anyHit) begin
                    shadeColor[ch] = curColor[ch] >> 1;
                end else begin
                    shadeColor[ch] = curColor[ch];
                end
            end
        end else if (anyHit) begin
            shadeColor = hitColor;
        end else begin
            shadeColor = clearColor;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= rayDone;
        end
    end

    // held until the next ray commits
    always_ff @(posedge clk) begin
        if (rayDone) begin
            outX         <= curX;
            outY         <= curY;
            outHit       <= anyHit;
            outPrimIndex <= anyHit ? bestIndex : '0;
            outColor     <= shadeColor;
        end
    end

    // a commit needs at least the SEQ_DONE to SEQ_IDLE turn between rays
    singleStrobe: assert property (@(posedge clk) disable iff (!resetn)
        valid |=> !valid);

endmodule

/* rtl/rayHitTracker.sv */
`timescale 1ns/1ns

module rayHitTracker (
    input  logic               clk,
    input  logic               resetn,
    input  logic               rayStart,
    input  logic               batchActive,
    input  logic               batchHit,
    input  rayPkg::fixedT      batchNearT,
    input  rayPkg::laneIndexT  batchLane,
    input  rayPkg::primIndexT  batchStart,
    input  rayPkg::colorT      boxColor [rayPkg::BATCH_SIZE],
    output logic               anyHit,
    output rayPkg::fixedT      bestT,
    output rayPkg::primIndexT  bestIndex,
    output rayPkg::laneIndexT  bestLane,
    output rayPkg::colorT      hitColor
);

    // colours of the batch that held the best hit
    rayPkg::colorT laneColor [rayPkg::BATCH_SIZE];
    logic          takeHit;

    // earlier batches win ties, so only strictly nearer hits replace
    assign takeHit = batchActive && batchHit && (batchNearT < bestT);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            anyHit <= 1'b0;
            bestT  <= rayPkg::FIXED_MAX;
        end else if (rayStart) begin
            anyHit <= 1'b0;
            bestT  <= rayPkg::FIXED_MAX;
        end else if (takeHit) begin
            anyHit <= 1'b1;
            bestT  <= batchNearT;
        end
    end

    always_ff @(posedge clk) begin
        if (takeHit) begin
            bestIndex <= batchStart + rayPkg::primIndexT'(batchLane);
            bestLane  <= batchLane;
            laneColor <= boxColor;
        end
    end

    assign hitColor = laneColor[bestLane];

endmodule

/* rtl/rayBoxBatchTest.sv */
`timescale 1ns/1ns

module rayBoxBatchTest (
    input  rayPkg::fixedVec3T  origin,
    input  rayPkg::fixedVec3T  invDir,
    input  rayPkg::fixedT      maxT,
    input  rayPkg::fixedVec3T  boxLo [rayPkg::BATCH_SIZE],
    input  rayPkg::fixedVec3T  boxHi [rayPkg::BATCH_SIZE],
    input  rayPkg::laneMaskT   laneMask,
    output logic               batchHit,
    output rayPkg::fixedT      batchNearT,
    output rayPkg::laneIndexT  batchLane
);

    rayPkg::fixedT    laneNear [rayPkg::BATCH_SIZE];
    rayPkg::laneMaskT laneHit;

    // distance along the ray to one slab plane
    function automatic rayPkg::fixedT slabDist(
        input rayPkg::fixedT bound,
        input rayPkg::fixedT org,
        input rayPkg::fixedT inv
    );
        rayPkg::fixedT      diff;
        logic signed [63:0] wideDiff;
        logic signed [63:0] wideInv;
        logic signed [63:0] product;
        diff     = bound - org;
        wideDiff = 64'(diff);
        wideInv  = 64'(inv);
        product  = wideDiff * wideInv;
        return rayPkg::fixedT'(product >>> rayPkg::FRAC_BITS);
    endfunction

    // ------------------------------------------------------------------------
    // slab test, all lanes in parallel
    // ------------------------------------------------------------------------

    always_comb begin
        rayPkg::fixedT tA;
        rayPkg::fixedT tB;
        rayPkg::fixedT axisNear;
        rayPkg::fixedT axisFar;
        rayPkg::fixedT tNear;
        rayPkg::fixedT tFar;
        for (int lane = 0; lane < rayPkg::BATCH_SIZE; lane++) begin
            // entry never before the origin
            tNear = '0;
            tFar  = rayPkg::FIXED_MAX;
            for (int axis = 0; axis < 3; axis++) begin
                tA = slabDist(boxLo[lane][axis], origin[axis], invDir[axis]);
                tB = slabDist(boxHi[lane][axis], origin[axis], invDir[axis]);
                if (tA < tB) begin
                    axisNear = tA;
                    axisFar  = tB;
                end else begin
                    axisNear = tB;
                    axisFar  = tA;
                end
                if (axisNear > tNear) begin
                    tNear = axisNear;
                end
                if (axisFar < tFar) begin
                    tFar = axisFar;
                end
            end
            laneNear[lane] = tNear;
            laneHit[lane]  = laneMask[lane] && (tNear <= tFar) && (tNear < maxT);
        end
    end

    // ------------------------------------------------------------------------
    // nearest hitting lane
    // ------------------------------------------------------------------------

    always_comb begin
        batchHit   = 1'b0;
        batchNearT = rayPkg::FIXED_MAX;
        batchLane  = '0;
        // strict compare, so the lower lane keeps a tie
        for (int lane = 0; lane < rayPkg::BATCH_SIZE; lane++) begin
            if (laneHit[lane] && (!batchHit || (laneNear[lane] < batchNearT))) begin
                batchHit   = 1'b1;
                batchNearT = laneNear[lane];
                batchLane  = rayPkg::laneIndexT'(lane);
            end
        end
    end

endmodule

/* rtl/rayRangeSequencer.sv */
`timescale 1ns/1ns

module rayRangeSequencer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                addInput,
    input  rayPkg::rayKindE     inKind,
    input  rayPkg::pixelCoordT  inX,
    input  rayPkg::pixelCoordT  inY,
    input  rayPkg::fixedVec3T   inOrigin,
    input  rayPkg::fixedVec3T   inInvDir,
    input  rayPkg::fixedT       inMaxT,
    input  rayPkg::colorT       inColor,
    input  rayPkg::primIndexT   inPrimStart,
    input  rayPkg::primCountT   inPrimCount,
    input  logic                anyHit,
    input  logic                outputStall,
    output logic                inputFull,
    output rayPkg::rayKindE     curKind,
    output rayPkg::pixelCoordT  curX,
    output rayPkg::pixelCoordT  curY,
    output rayPkg::fixedVec3T   curOrigin,
    output rayPkg::fixedVec3T   curInvDir,
    output rayPkg::fixedT       curMaxT,
    output rayPkg::colorT       curColor,
    output rayPkg::primIndexT   batchStart,
    output rayPkg::laneMaskT    laneMask,
    output logic                batchActive,
    output logic                rayStart,
    output logic                rayDone
);

    rayPkg::seqStateE   state;

    // one-entry input buffer
    rayPkg::rayKindE    bufKind;
    rayPkg::pixelCoordT bufX;
    rayPkg::pixelCoordT bufY;
    rayPkg::fixedVec3T  bufOrigin;
    rayPkg::fixedVec3T  bufInvDir;
    rayPkg::fixedT      bufMaxT;
    rayPkg::colorT      bufColor;
    rayPkg::primIndexT  bufStart;
    rayPkg::primCountT  bufCount;

    rayPkg::primIndexT  roundedCount;
    rayPkg::primIndexT  bufEnd;
    rayPkg::primIndexT  bufAlignedEnd;
    rayPkg::primIndexT  curEnd;
    rayPkg::primIndexT  alignedEnd;
    rayPkg::primIndexT  nextStart;
    logic               shadowExit;

    // count rounded up to whole batches
    assign roundedCount = ((rayPkg::primIndexT'(bufCount) +
                            rayPkg::primIndexT'(rayPkg::BATCH_SIZE - 1))
                           >> rayPkg::BATCH_WIDTH) << rayPkg::BATCH_WIDTH;
    assign bufEnd        = bufStart + rayPkg::primIndexT'(bufCount);
    assign bufAlignedEnd = bufStart + roundedCount;
    assign nextStart     = batchStart + rayPkg::primIndexT'(rayPkg::BATCH_SIZE);

    assign shadowExit  = (curKind == rayPkg::RAY_SHADOW) && anyHit;
    assign rayStart    = (state == rayPkg::SEQ_IDLE) && inputFull;
    assign batchActive = (state == rayPkg::SEQ_TRAVERSE) && !shadowExit;
    assign rayDone     = (state == rayPkg::SEQ_DONE) && !outputStall;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            inputFull <= 1'b0;
        end else if (addInput && !inputFull) begin
            inputFull <= 1'b1;
        end else if (rayStart) begin
            inputFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (addInput && !inputFull) begin
            bufKind   <= inKind;
            bufX      <= inX;
            bufY      <= inY;
            bufOrigin <= inOrigin;
            bufInvDir <= inInvDir;
            bufMaxT   <= inMaxT;
            bufColor  <= inColor;
            bufStart  <= inPrimStart;
            bufCount  <= inPrimCount;
        end
    end

    // current ray, loaded as it leaves the buffer
    always_ff @(posedge clk) begin
        if (rayStart) begin
            curKind    <= bufKind;
            curX       <= bufX;
            curY       <= bufY;
            curOrigin  <= bufOrigin;
            curInvDir  <= bufInvDir;
            curMaxT    <= bufMaxT;
            curColor   <= bufColor;
            curEnd     <= bufEnd;
            alignedEnd <= bufAlignedEnd;
        end
    end

    // ------------------------------------------------------------------------
    // traversal FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= rayPkg::SEQ_IDLE;
            batchStart <= '0;
        end else begin
            case (state)
                rayPkg::SEQ_IDLE: begin
                    if (rayStart) begin
                        batchStart <= bufStart;
                        // empty range skips straight to the result
                        if (bufCount == '0) begin
                            state <= rayPkg::SEQ_DONE;
                        end else begin
                            state <= rayPkg::SEQ_TRAVERSE;
                        end
                    end
                end
                rayPkg::SEQ_TRAVERSE: begin
                    if (shadowExit) begin
                        state <= rayPkg::SEQ_DONE;
                    end else begin
                        batchStart <= nextStart;
                        if (nextStart == alignedEnd) begin
                            state <= rayPkg::SEQ_DONE;
                        end
                    end
                end
                rayPkg::SEQ_DONE: begin
                    if (rayDone) begin
                        state <= rayPkg::SEQ_IDLE;
                    end
                end
                default: begin
                    state <= rayPkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // lanes past the true end of the range take no part
    always_comb begin
        for (int lane = 0; lane < rayPkg::BATCH_SIZE; lane++) begin
            laneMask[lane] = (batchStart + rayPkg::primIndexT'(lane)) < curEnd;
        end
    end

    batchInRange: assert property (@(posedge clk) disable iff (!resetn)
        batchActive |-> (batchStart < alignedEnd));

endmodule

/* rtl/rayPkg.sv */
package rayPkg;

    // ------------------------------------------------------------------------
    // fixed point
    // ------------------------------------------------------------------------

    // Q16.16, signed
    localparam int FRAC_BITS = 16;

    typedef logic signed [31:0] fixedT;

    // index 0 is x, 1 is y, 2 is z
    typedef fixedT [2:0] fixedVec3T;

    // distance used before any box has hit
    localparam fixedT FIXED_MAX = 32'sh7fff_ffff;

    // ------------------------------------------------------------------------
    // pixel, colour and primitive indexing
    // ------------------------------------------------------------------------

    // channel 0 is red, then green, then blue
    typedef logic [2:0][7:0] colorT;

    typedef logic [15:0] primIndexT;

    // count of one contiguous primitive range
    typedef logic [7:0] primCountT;

    typedef logic [11:0] pixelCoordT;

    // ------------------------------------------------------------------------
    // batch of boxes tested in one cycle
    // ------------------------------------------------------------------------

    localparam int BATCH_SIZE = 4;
    localparam int BATCH_WIDTH = 2;

    // one bit per lane, set when the lane holds a primitive of the range
    typedef logic [BATCH_SIZE-1:0] laneMaskT;

    typedef logic [BATCH_WIDTH-1:0] laneIndexT;

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------

    // primary rays keep the closest hit, shadow rays stop at the first one
    typedef enum logic {
        RAY_PRIMARY = 1'b0,
        RAY_SHADOW  = 1'b1
    } rayKindE;

    typedef enum logic [1:0] {
        SEQ_IDLE     = 2'd0,
        SEQ_TRAVERSE = 2'd1,
        SEQ_DONE     = 2'd2
    } seqStateE;

endpackage
